/* Bender.yml */
package:
  name: comb_filter

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/comb_pkg.sv
      - hdl/comb_cfg_regs.sv
      - comb/comb_delay_ram.sv
      - comb/comb_core.sv
      - hdl/comb_filter_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/tb_comb_filter.sv

/* comb/comb_core.sv */
/*
  Feedback comb datapath, y(n) = x(n) + (g * y(n-D)) >>> Q.
  Sequences one sample at a time through the delay memory and moves the
  read pointer behind the write pointer when a new delay is requested.
*/

`timescale 1ns/1ns

`include "comb_params.svh"

module comb_core (
  input  logic              clk,
  input  logic              rst_n,
  input  comb_pkg::sample_t x,
  input  logic              x_valid,
  output comb_pkg::sample_t y,
  output logic              y_valid,
  output comb_pkg::addr_t   wr_addr,
  output comb_pkg::sample_t wr_data,
  output logic              wr_valid,
  output comb_pkg::addr_t   rd_addr,
  output logic              rd_avalid,
  input  comb_pkg::sample_t rd_data,
  input  logic              rd_dvalid,
  output logic              rd_dready,
  input  logic              calc_delay,
  input  comb_pkg::addr_t   delay_time,
  input  comb_pkg::gain_t   delay_gain
);

  import comb_pkg::*;

  localparam int n_bits    = `COMB_N_BITS;
  localparam int q_bits    = `COMB_Q_BITS;

  typedef enum logic [1:0] {
    ST_RD_REQ,
    ST_RD_RES,
    ST_WAIT_X,
    ST_WR
  } seq_state_t;

  typedef enum logic [1:0] {
    DC_IDLE,
    DC_DIFF,
    DC_WRAP
  } dc_state_t;

  seq_state_t seq_state;
  dc_state_t  dc_state;

  addr_t   wr_ptr;
  addr_t   rd_ptr;
  addr_t   delay_off;
  addr_t   wrap_diff;
  sample_t y_delay;

  logic signed [2*n_bits-1:0]  prod_full;
  logic signed [2*n_bits-1:0]  prod_shift;

  ////////////////////////////////////////
  // Delay term arithmetic
  ////////////////////////////////////////

  // Full signed product, then arithmetic shift back to the sample scale
  assign prod_full  = rd_data * delay_gain;
  assign prod_shift = prod_full >>> q_bits;

  // Distance behind the write pointer, wraps modulo the memory depth
  assign wrap_diff = wr_ptr - delay_off;

  // Write port is active for the single cycle after accept
  assign wr_valid = (seq_state == ST_WR);
  assign wr_addr  = wr_ptr;
  assign wr_data  = y;

  ////////////////////////////////////////
  // Sample sequencer
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seq_state <= ST_RD_REQ;
      wr_ptr    <= '0;
      rd_addr   <= '0;
      rd_avalid <= 1'b0;
      rd_dready <= 1'b0;
      y_valid   <= 1'b0;
    end else begin
      rd_avalid <= 1'b0;
      y_valid   <= 1'b0;

      case (seq_state)
        ST_RD_REQ: begin
          rd_addr   <= rd_ptr;
          rd_avalid <= 1'b1;
          rd_dready <= 1'b1;
          seq_state <= ST_RD_RES;
        end

        ST_RD_RES: begin
          if (rd_dvalid && rd_dready) begin
            rd_dready <= 1'b0;
            seq_state <= ST_WAIT_X;
          end
        end

        // Strobes outside this state are dropped
        ST_WAIT_X: begin
          if (x_valid) begin
            y_valid   <= 1'b1;
            seq_state <= ST_WR;
          end
        end

        ST_WR: begin
          wr_ptr    <= wr_ptr + addr_t'(1);
          seq_state <= ST_RD_REQ;
        end

        default: seq_state <= ST_RD_REQ;
      endcase
    end
  end

  // Delay term and output sample
  always_ff @(posedge clk) begin
    if (seq_state == ST_RD_RES && rd_dvalid && rd_dready) begin
      y_delay <= prod_shift[n_bits-1:0];
    end
    if (seq_state == ST_WAIT_X && x_valid) begin
      y <= x + y_delay;
    end
  end

  ////////////////////////////////////////
  // Read pointer and delay recalculation
  ////////////////////////////////////////

  // The wrap step points at the read for the write after the current one,
  // so the target is wr_ptr - (D - 1) in every sequencer state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dc_state  <= DC_IDLE;
      rd_ptr    <= '1;
      delay_off <= '0;
    end else begin
      if (seq_state == ST_RD_REQ) begin
        rd_ptr <= rd_ptr + addr_t'(1);
      end

      case (dc_state)
        DC_IDLE: begin
          if (calc_delay) begin
            dc_state <= DC_DIFF;
          end
        end

        DC_DIFF: begin
          delay_off <= delay_time - addr_t'(1);
          dc_state  <= DC_WRAP;
        end

        // Overrides the increment above
        DC_WRAP: begin
          rd_ptr   <= wrap_diff;
          dc_state <= DC_IDLE;
        end

        default: dc_state <= DC_IDLE;
      endcase
    end
  end

endmodule

/* comb/comb_delay_ram.sv */
/*
  Delay memory holding past filter outputs.
  One write port and one read port whose data arrives a fixed number of
  cycles after the request, so the port never stalls.
*/

`timescale 1ns/1ns

`include "comb_params.svh"

module comb_delay_ram (
  input  logic              clk,
  input  logic              rst_n,
  input  comb_pkg::addr_t   wr_addr,
  input  comb_pkg::sample_t wr_data,
  input  logic              wr_valid,
  input  comb_pkg::addr_t   rd_addr,
  input  logic              rd_avalid,
  output comb_pkg::sample_t rd_data,
  output logic              rd_dvalid,
  input  logic              rd_dready
);

  import comb_pkg::*;

  localparam int mem_depth  = 2 ** `COMB_ADDR_WIDTH;
  localparam int rd_latency = `COMB_RD_LATENCY;

  // Starts out silent, so early echoes read zero
  sample_t mem [mem_depth] = '{default: '0};

  logic [rd_latency-1:0] rd_pipe;

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read data is held until the next request
  always_ff @(posedge clk) begin
    if (rd_avalid && rd_dready) begin
      rd_data <= mem[rd_addr];
    end
  end

  ////////////////////////////////////////
  // Data-valid pipeline
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_pipe <= '0;
    end else begin
      rd_pipe[0] <= rd_avalid;
      for (int s = 1; s < rd_latency; s++) begin
        rd_pipe[s] <= rd_pipe[s-1];
      end
    end
  end

  assign rd_dvalid = rd_pipe[rd_latency-1];

endmodule

/* comb_filter.f */
+incdir+common
common/comb_pkg.sv
hdl/comb_cfg_regs.sv
comb/comb_delay_ram.sv
comb/comb_core.sv
hdl/comb_filter_top.sv
test/tb_comb_filter.sv

/* common/comb_params.svh */
/*
  Build-time constants for the comb filter.
  Included by the package and by every block that sizes logic from these values.
*/

`ifndef COMB_PARAMS_SVH
`define COMB_PARAMS_SVH

// Sample and gain word width
`define COMB_N_BITS 16

// Fraction bits of the gain, so 1.0 is 1 << COMB_Q_BITS
`define COMB_Q_BITS 8

// Delay memory address width, depth is 2**COMB_ADDR_WIDTH words
`define COMB_ADDR_WIDTH 6

// Cycles from a read request to its data-valid
`define COMB_RD_LATENCY 2

// Delay in samples after reset
`define COMB_RESET_DELAY 1

`endif

/* common/comb_pkg.sv */
/*
  Shared word types of the comb filter.
  Blocks import it in their body and use scoped names on their ports.
*/

`include "comb_params.svh"

package comb_pkg;

  ////////////////////////////////////////
  // Datapath words
  ////////////////////////////////////////

  // Audio sample, two's complement
  typedef logic signed [`COMB_N_BITS-1:0] sample_t;

  // Gain in fixed point with COMB_Q_BITS fraction bits
  typedef logic signed [`COMB_N_BITS-1:0] gain_t;

  ////////////////////////////////////////
  // Addressing
  ////////////////////////////////////////

  // Word address into the delay memory
  typedef logic [`COMB_ADDR_WIDTH-1:0] addr_t;

  // Register selector, 0 is the delay and 1 is the gain
  typedef logic reg_addr_t;

endpackage

/* hdl/comb_cfg_regs.sv */
/*
  Delay and gain configuration registers with readback.
  A delay write also raises a one-cycle pulse that makes the core
  recompute its read pointer.
*/

`timescale 1ns/1ns

`include "comb_params.svh"

module comb_cfg_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  comb_pkg::reg_addr_t reg_addr,
  input  logic [15:0]         reg_wdata,
  input  logic                reg_write,
  output logic [15:0]         reg_rdata,
  output comb_pkg::addr_t     delay_time,
  output comb_pkg::gain_t     delay_gain,
  output logic                calc_delay
);

  import comb_pkg::*;

  localparam int addr_bits = `COMB_ADDR_WIDTH;

  logic wr_delay;
  logic wr_gain;

  // Selector 0 is the delay, 1 is the gain
  assign wr_delay = reg_write && (reg_addr == reg_addr_t'(0));
  assign wr_gain  = reg_write && (reg_addr == reg_addr_t'(1));

  ////////////////////////////////////////
  // Register storage
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      delay_time <= addr_t'(`COMB_RESET_DELAY);
      delay_gain <= '0;
      calc_delay <= 1'b0;
    end else begin
      // Pulse lands in the cycle where the new delay is visible
      calc_delay <= wr_delay;
      if (wr_delay) begin
        delay_time <= reg_wdata[addr_bits-1:0];
      end
      if (wr_gain) begin
        delay_gain <= gain_t'(reg_wdata);
      end
    end
  end

  ////////////////////////////////////////
  // Readback
  ////////////////////////////////////////

  always_comb begin
    case (reg_addr)
      reg_addr_t'(0): reg_rdata = {{(16 - addr_bits){1'b0}}, delay_time};
      default:        reg_rdata = delay_gain;
    endcase
  end

endmodule

/* hdl/comb_filter_top.sv */
/*
  Comb filter subsystem top.
  Joins the configuration registers, the filter core and its delay memory.
*/

`timescale 1ns/1ns

module comb_filter_top (
  input  logic                clk,
  input  logic                rst_n,
  input  comb_pkg::reg_addr_t reg_addr,
  input  logic [15:0]         reg_wdata,
  input  logic                reg_write,
  output logic [15:0]         reg_rdata,
  input  comb_pkg::sample_t   x,
  input  logic                x_valid,
  output comb_pkg::sample_t   y,
  output logic                y_valid
);

  import comb_pkg::*;

  // Configuration to core
  addr_t   delay_time;
  gain_t   delay_gain;
  logic    calc_delay;

  // Core to delay memory
  addr_t   wr_addr;
  sample_t wr_data;
  logic    wr_valid;
  addr_t   rd_addr;
  logic    rd_avalid;
  sample_t rd_data;
  logic    rd_dvalid;
  logic    rd_dready;

  comb_cfg_regs u_regs (
    .clk, .rst_n, .reg_addr, .reg_wdata, .reg_write, .reg_rdata,
    .delay_time, .delay_gain, .calc_delay
  );

  comb_core u_core (
    .clk, .rst_n, .x, .x_valid, .y, .y_valid,
    .wr_addr, .wr_data, .wr_valid, .rd_addr, .rd_avalid, .rd_data, .rd_dvalid, .rd_dready,
    .calc_delay, .delay_time, .delay_gain
  );

  comb_delay_ram u_ram (
    .clk, .rst_n, .wr_addr, .wr_data, .wr_valid,
    .rd_addr, .rd_avalid, .rd_data, .rd_dvalid, .rd_dready
  );

endmodule

/* test/tb_comb_filter.sv */
/*
  Self-checking testbench for the comb filter subsystem.
  Drives register writes and samples on falling edges and checks every
  output against a reference model of the feedback comb.
*/

`timescale 1ns/1ns

`include "comb_params.svh"

module tb_comb_filter;

  import comb_pkg::*;

  logic        clk;
  logic        rst_n;
  reg_addr_t   reg_addr;
  logic [15:0] reg_wdata;
  logic        reg_write;
  logic [15:0] reg_rdata;
  sample_t     x;
  logic        x_valid;
  sample_t     y;
  logic        y_valid;

  logic [31:0] lfsr_state = 32'ha94;
  sample_t     hist [512];
  int          sample_n = 0;
  int          yv_count = 0;
  int          count_before;
  sample_t     exp_q [$];
  sample_t     exp_y;
  sample_t     xs;
  logic [15:0] mag;

  // Config seen by the next sample, and the last values written
  addr_t cur_delay  = addr_t'(`COMB_RESET_DELAY);
  gain_t cur_gain   = '0;
  addr_t pend_delay = addr_t'(`COMB_RESET_DELAY);
  gain_t pend_gain  = '0;

  comb_filter_top uut (
    .clk, .rst_n, .reg_addr, .reg_wdata, .reg_write, .reg_rdata,
    .x, .x_valid, .y, .y_valid
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [15:0] take_bits(input int count);
    logic [15:0] val;
    val = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[14:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // y(n) = x(n) + (g * y(n-D)) >>> Q, with silence before the first output
  function automatic sample_t ref_output(input sample_t x_in, input addr_t d, input gain_t g);
    sample_t                          past;
    logic signed [2*`COMB_N_BITS-1:0] prod;
    logic signed [2*`COMB_N_BITS-1:0] term;
    past = (sample_n >= int'(d)) ? hist[sample_n - int'(d)] : sample_t'(0);
    prod = past * g;
    term = prod >>> `COMB_Q_BITS;
    hist[sample_n] = x_in + sample_t'(term[`COMB_N_BITS-1:0]);
    return hist[sample_n];
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_sample(input string name, input sample_t expv, input sample_t act);
    if (act !== expv) begin
      abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %h, got %h",
                          $time, name, expv, act));
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] expv,
                            input logic [15:0] act);
    if (act !== expv) begin
      abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %h, got %h",
                          $time, name, expv, act));
    end
  endtask

  // Compares every output pulse with the oldest expected value
  always @(negedge clk) begin
    if (y_valid) begin
      yv_count++;
      if (exp_q.size() == 0) begin
        abort_run("An output pulse arrived with no sample outstanding");
      end else begin
        exp_y = exp_q.pop_front();
        check_sample("y", exp_y, y);
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  task automatic write_reg(input reg_addr_t a, input logic [15:0] data);
    @(negedge clk);
    reg_addr  = a;
    reg_wdata = data;
    reg_write = 1'b1;
    @(negedge clk);
    reg_write = 1'b0;
    // Leave room for the read pointer recalculation
    repeat (4) @(negedge clk);
    if (a == reg_addr_t'(0)) pend_delay = data[`COMB_ADDR_WIDTH-1:0];
    else pend_gain = gain_t'(data);
  endtask

  task automatic read_reg(input reg_addr_t a, input logic [15:0] expv, input string name);
    @(negedge clk);
    reg_addr = a;
    @(negedge clk);
    check_word(name, expv, reg_rdata);
  endtask

  // The core fetches the delayed word before the strobe, so a config
  // write reaches the sample after the next one
  task automatic send_sample(input sample_t s);
    bit seen;
    exp_q.push_back(ref_output(s, cur_delay, cur_gain));
    sample_n++;
    cur_delay = pend_delay;
    cur_gain  = pend_gain;
    @(negedge clk);
    x       = s;
    x_valid = 1'b1;
    @(negedge clk);
    x_valid = 1'b0;
    seen = 1'b0;
    for (int c = 0; c < 40 && !seen; c++) begin
      if (y_valid) seen = 1'b1;
      else @(negedge clk);
    end
    if (!seen) abort_run("Timed out waiting for y_valid after a sample strobe");
    else repeat (8) @(negedge clk);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    reg_addr  = reg_addr_t'(0);
    reg_wdata = '0;
    reg_write = 1'b0;
    x         = '0;
    x_valid   = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (8) @(negedge clk);

    // Reset values, then pass-through with zero gain
    read_reg(reg_addr_t'(0), 16'd1, "reg_rdata delay");
    read_reg(reg_addr_t'(1), 16'd0, "reg_rdata gain");
    for (int i = 0; i < 10; i++) send_sample(sample_t'(take_bits(16)));

    // Silence the history, then an impulse echoing every 5 samples
    for (int i = 0; i < 5; i++) send_sample('0);
    write_reg(reg_addr_t'(0), 16'd5);
    write_reg(reg_addr_t'(1), 16'd128);
    read_reg(reg_addr_t'(0), 16'd5, "reg_rdata delay");
    read_reg(reg_addr_t'(1), 16'd128, "reg_rdata gain");
    send_sample(16'sh4000);
    for (int i = 0; i < 20; i++) send_sample('0);

    // Random gain below 1.0 and random delay over a long stream
    mag = take_bits(8);
    if (take_bits(1) == 16'd1) mag = -mag;
    write_reg(reg_addr_t'(1), mag);
    mag = take_bits(6);
    if (mag == 16'd0) mag = 16'd1;
    write_reg(reg_addr_t'(0), mag);
    read_reg(reg_addr_t'(0), mag, "reg_rdata delay");
    for (int i = 0; i < 100; i++) send_sample(sample_t'(take_bits(16)));

    // Delay change in the middle of a stream
    write_reg(reg_addr_t'(0), 16'd5);
    write_reg(reg_addr_t'(1), 16'd200);
    for (int i = 0; i < 10; i++) send_sample(sample_t'(take_bits(16)));
    write_reg(reg_addr_t'(0), 16'd20);
    for (int i = 0; i < 30; i++) send_sample(sample_t'(take_bits(16)));

    // Negative gain against full-scale negative input
    write_reg(reg_addr_t'(1), 16'hff40);
    write_reg(reg_addr_t'(0), 16'd3);
    for (int i = 0; i < 12; i++) begin
      xs = (i % 3 == 2) ? sample_t'(take_bits(16)) : 16'sh8000;
      send_sample(xs);
    end

    // One strobe gives one pulse, and an idle input gives none
    count_before = yv_count;
    send_sample(sample_t'(take_bits(16)));
    repeat (42) @(negedge clk);
    if (yv_count != count_before + 1) begin
      abort_run("A single strobe did not give exactly one y_valid pulse");
    end
    count_before = yv_count;
    repeat (50) @(negedge clk);
    if (yv_count != count_before) begin
      abort_run("y_valid pulsed while no sample was being driven");
    end else if (exp_q.size() != 0) begin
      abort_run("Some expected outputs never arrived");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule
